// File: gba_pkg.sv
// Shared types, I/O register offsets, interrupt bit positions and pad timing
`default_nettype none

package gba_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] addr_t;
    typedef logic [3:0]  sel_t;
    typedef logic [15:0] half_t;
    typedef logic [7:0]  led_t;

    localparam int NUM_IRQ = 14;
    typedef logic [NUM_IRQ-1:0] irq_t;

    // Word offsets inside the I/O space
    localparam addr_t KEYINPUT_OFS = 12'h130;
    localparam addr_t IE_IF_OFS    = 12'h200;
    localparam addr_t IME_OFS      = 12'h208;
    localparam addr_t LED_REG0_OFS = 12'h300;
    localparam addr_t LED_REG1_OFS = 12'h304;
    localparam addr_t LED_REG2_OFS = 12'h308;
    localparam addr_t LED_REG3_OFS = 12'h30C;

    // Interrupt source bit positions in irq_t, IE and IF
    localparam int IRQ_VBLANK   = 0;
    localparam int IRQ_HBLANK   = 1;
    localparam int IRQ_VCOUNT   = 2;
    localparam int IRQ_TIMER0   = 3;
    localparam int IRQ_TIMER1   = 4;
    localparam int IRQ_TIMER2   = 5;
    localparam int IRQ_TIMER3   = 6;
    localparam int IRQ_SERIAL   = 7;
    localparam int IRQ_DMA0     = 8;
    localparam int IRQ_DMA1     = 9;
    localparam int IRQ_DMA2     = 10;
    localparam int IRQ_DMA3     = 11;
    localparam int IRQ_KEYPAD   = 12;
    localparam int IRQ_GAME_PAK = 13;

    // Pad clock timing kept short for simulation
    localparam int PAD_HALF_PERIOD = 4;
    typedef logic [3:0] pad_cnt_t;
    localparam pad_cnt_t PAD_HALF_LAST  = pad_cnt_t'(PAD_HALF_PERIOD - 1);
    localparam pad_cnt_t PAD_LATCH_LAST = pad_cnt_t'(2 * PAD_HALF_PERIOD - 1);

    typedef enum logic [2:0] {
        IDLE,
        LATCH,
        CLK_LOW,
        CLK_HIGH,
        DONE
    } pad_state_t;

endpackage

`default_nettype wire

// File: gba_bus_if.sv
// Wishbone classic bus interface and interrupt register interface
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
    logic            cyc;
    logic            stb;
    logic            we;
    gba_pkg::addr_t  adr;
    gba_pkg::word_t  dat_w;
    gba_pkg::word_t  dat_r;
    gba_pkg::sel_t   sel;
    logic            ack;

    modport master (output cyc, stb, we, adr, dat_w, sel, input dat_r, ack);
    modport slave  (input cyc, stb, we, adr, dat_w, sel, output dat_r, ack);
endinterface

interface intr_if;
    gba_pkg::half_t  ie_wdata;
    logic            ie_we;
    gba_pkg::half_t  ack_mask;
    logic            ack_we;
    gba_pkg::half_t  ie;
    gba_pkg::half_t  if_flags;
    logic            ime;

    modport regs (output ie_wdata, ie_we, ack_mask, ack_we, ime, input ie, if_flags);
    modport ctrl (input ie_wdata, ie_we, ack_mask, ack_we, ime, output ie, if_flags);
endinterface

`default_nettype wire

// File: io_reg_file.sv
// Wishbone slave with I/O offset decode, LED registers, IME and IE/IF access
`timescale 1ns/1ps
`default_nettype none

module io_reg_file (
    input  logic           clock,
    input  logic           arst_n,
    wb_if.slave            bus,
    intr_if.regs           intr,
    input  gba_pkg::half_t buttons,
    output gba_pkg::word_t led_regs [4]
);

    gba_pkg::addr_t word_adr;
    gba_pkg::word_t rd_data;
    gba_pkg::word_t ie_merged;
    logic           req;
    logic           wr_req;
    logic           led_hit;
    logic           ie_if_hit;
    logic           ime_q;

    // Byte-lane merge of new write data into an old value
    function automatic gba_pkg::word_t merge_lanes(
        input gba_pkg::word_t old_val,
        input gba_pkg::word_t new_val,
        input gba_pkg::sel_t  lanes
    );
        gba_pkg::word_t res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = lanes[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
        end
        return res;
    endfunction

    // New request only while ack is low, so each access is seen once
    assign req       = bus.cyc && bus.stb && !bus.ack;
    assign wr_req    = req && bus.we;
    assign word_adr  = {bus.adr[11:2], 2'b00};
    assign ie_if_hit = (word_adr == gba_pkg::IE_IF_OFS);

    always_comb begin
        rd_data = '0;
        led_hit = 1'b0;
        case (word_adr)
            gba_pkg::KEYINPUT_OFS: rd_data = {16'h0000, buttons};
            gba_pkg::IE_IF_OFS:    rd_data = {intr.if_flags, intr.ie};
            gba_pkg::IME_OFS:      rd_data = {31'h0, ime_q};
            gba_pkg::LED_REG0_OFS,
            gba_pkg::LED_REG1_OFS,
            gba_pkg::LED_REG2_OFS,
            gba_pkg::LED_REG3_OFS: begin
                rd_data = led_regs[word_adr[3:2]];
                led_hit = 1'b1;
            end
            default: ;
        endcase
    end

    // IE write uses lanes 0-1, IF acknowledge uses lanes 2-3
    assign ie_merged     = merge_lanes({16'h0000, intr.ie}, bus.dat_w, bus.sel);
    assign intr.ie_wdata = ie_merged[15:0];
    assign intr.ie_we    = wr_req && ie_if_hit && (bus.sel[0] || bus.sel[1]);
    assign intr.ack_mask = bus.dat_w[31:16] & {{8{bus.sel[3]}}, {8{bus.sel[2]}}};
    assign intr.ack_we   = wr_req && ie_if_hit && (bus.sel[2] || bus.sel[3]);
    assign intr.ime      = ime_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bus.ack   <= 1'b0;
            bus.dat_r <= '0;
            ime_q     <= 1'b0;
            led_regs  <= '{default: '0};
        end else begin
            bus.ack <= req;
            if (req && !bus.we) begin
                bus.dat_r <= rd_data;
            end
            if (wr_req) begin
                if (led_hit) begin
                    led_regs[word_adr[3:2]] <=
                        merge_lanes(led_regs[word_adr[3:2]], bus.dat_w, bus.sel);
                end
                if (word_adr == gba_pkg::IME_OFS && bus.sel[0]) begin
                    ime_q <= bus.dat_w[0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: interrupt_controller.sv
// Interrupt controller with IE, IF edge capture, write-one-to-clear and nirq
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller (
    input  logic          clock,
    input  logic          arst_n,
    input  gba_pkg::irq_t sources,
    intr_if.ctrl          intr,
    output logic          nirq
);

    gba_pkg::irq_t  src_sync;
    gba_pkg::irq_t  src_prev;
    gba_pkg::half_t rise;
    gba_pkg::half_t clr;
    gba_pkg::half_t ie_q;
    gba_pkg::half_t if_q;

    // One synchronizer stage, then rising edge detect
    assign rise = gba_pkg::half_t'(src_sync & ~src_prev);
    assign clr  = intr.ack_we ? intr.ack_mask : '0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            src_sync <= '0;
            src_prev <= '0;
        end else begin
            src_sync <= sources;
            src_prev <= src_sync;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ie_q <= '0;
            if_q <= '0;
        end else begin
            if (intr.ie_we) begin
                ie_q <= intr.ie_wdata;
            end
            // A new edge beats a clear in the same cycle
            if_q <= (if_q & ~clr) | rise;
        end
    end

    // Registered active low request
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            nirq <= 1'b1;
        end else begin
            nirq <= !(intr.ime && |(ie_q & if_q));
        end
    end

    assign intr.ie       = ie_q;
    assign intr.if_flags = if_q;

endmodule

`default_nettype wire

// File: snes_pad_reader.sv
// SNES pad reader FSM driving latch and clock, shifting in sixteen buttons
`timescale 1ns/1ps
`default_nettype none

module snes_pad_reader (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           pad_data,
    output logic           pad_latch,
    output logic           pad_clock,
    output gba_pkg::half_t buttons
);

    gba_pkg::pad_state_t state;
    gba_pkg::pad_cnt_t   cnt;
    logic [3:0]          bit_cnt;
    gba_pkg::half_t      shift_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= gba_pkg::IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            shift_q <= '0;
            buttons <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                gba_pkg::IDLE: begin
                    cnt   <= '0;
                    state <= gba_pkg::LATCH;
                end
                gba_pkg::LATCH: begin
                    if (cnt == gba_pkg::PAD_LATCH_LAST) begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= gba_pkg::CLK_LOW;
                    end
                end
                gba_pkg::CLK_LOW: begin
                    if (cnt == gba_pkg::PAD_HALF_LAST) begin
                        // Sample on the edge where the pad clock rises
                        cnt     <= '0;
                        shift_q <= {pad_data, shift_q[15:1]};
                        state   <= gba_pkg::CLK_HIGH;
                    end
                end
                gba_pkg::CLK_HIGH: begin
                    if (cnt == gba_pkg::PAD_HALF_LAST) begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        state   <= (bit_cnt == 4'd15) ? gba_pkg::DONE : gba_pkg::CLK_LOW;
                    end
                end
                gba_pkg::DONE: begin
                    // Wire is active low so a pressed button reads as 1 here
                    buttons <= ~shift_q;
                    state   <= gba_pkg::IDLE;
                end
                default: state <= gba_pkg::IDLE;
            endcase
        end
    end

    assign pad_latch = (state == gba_pkg::LATCH);
    assign pad_clock = (state == gba_pkg::CLK_HIGH);

endmodule

`default_nettype wire

// File: led_debug_mux.sv
// Debug LED mux selecting a LED register byte or a button byte by switches
`timescale 1ns/1ps
`default_nettype none

module led_debug_mux (
    input  gba_pkg::led_t  sw,
    input  gba_pkg::word_t led_regs [4],
    input  gba_pkg::half_t buttons,
    output gba_pkg::led_t  led
);

    gba_pkg::word_t sel_reg;

    // Upper switch bits pick the register, lower two pick the byte
    assign sel_reg = led_regs[sw[3:2]];

    always_comb begin
        if (sw[7:4] == 4'h0) begin
            led = sel_reg[8*sw[1:0] +: 8];
        end else if (sw[7]) begin
            led = buttons[15:8];
        end else begin
            led = buttons[7:0];
        end
    end

endmodule

`default_nettype wire

// File: gba_io_top.sv
// Top level of the GBA I/O block connecting bus, interrupts, pad and LEDs
`timescale 1ns/1ps
`default_nettype none

module gba_io_top (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  gba_pkg::addr_t wb_adr,
    input  gba_pkg::word_t wb_dat_w,
    input  gba_pkg::sel_t  wb_sel,
    output gba_pkg::word_t wb_dat_r,
    output logic           wb_ack,
    input  gba_pkg::irq_t  irq_sources,
    output logic           nirq,
    output logic           pad_latch,
    output logic           pad_clock,
    input  logic           pad_data,
    input  gba_pkg::led_t  sw,
    output gba_pkg::led_t  led
);

    gba_pkg::half_t buttons;
    gba_pkg::word_t led_regs [4];

    wb_if   bus ();
    intr_if intr ();

    // External master drives the bus
    assign bus.cyc   = wb_cyc;
    assign bus.stb   = wb_stb;
    assign bus.we    = wb_we;
    assign bus.adr   = wb_adr;
    assign bus.dat_w = wb_dat_w;
    assign bus.sel   = wb_sel;
    assign wb_dat_r  = bus.dat_r;
    assign wb_ack    = bus.ack;

    io_reg_file regs (.clock, .arst_n, .bus(bus.slave), .intr(intr.regs),
                      .buttons, .led_regs);

    interrupt_controller intc (.clock, .arst_n, .sources(irq_sources),
                               .intr(intr.ctrl), .nirq);

    snes_pad_reader pad (.clock, .arst_n, .pad_data, .pad_latch, .pad_clock, .buttons);

    led_debug_mux leds (.sw, .led_regs, .buttons, .led);

endmodule

`default_nettype wire

// File: gba_io_sva.sv
// Concurrent assertions on the Wishbone handshake and the interrupt request
`timescale 1ns/1ps
`default_nettype none

module gba_io_sva (
    input logic           clock,
    input logic           arst_n,
    input logic           cyc,
    input logic           stb,
    input logic           ack,
    input logic           ime,
    input gba_pkg::half_t ie,
    input gba_pkg::half_t if_flags,
    input logic           nirq
);

    // Ack is a single cycle pulse
    ack_one_cycle: assert property (@(posedge clock) disable iff (!arst_n) ack |=> !ack)
        else $error("wb ack stayed high for more than one cycle");

    ack_after_request: assert property (@(posedge clock) disable iff (!arst_n)
        ack |-> $past(cyc && stb))
        else $error("wb ack raised without a request");

    // Request only with IME set and an enabled pending flag
    nirq_cause: assert property (@(posedge clock) disable iff (!arst_n)
        $fell(nirq) |-> $past(ime && (|(ie & if_flags))))
        else $error("nirq fell without an enabled pending interrupt");

endmodule

bind io_reg_file gba_io_sva bus_checks (
    .clock, .arst_n, .cyc(bus.cyc), .stb(bus.stb), .ack(bus.ack),
    .ime(1'b0), .ie(16'h0000), .if_flags(16'h0000), .nirq(1'b1));

bind interrupt_controller gba_io_sva irq_checks (
    .clock, .arst_n, .cyc(1'b0), .stb(1'b0), .ack(1'b0),
    .ime(intr.ime), .ie(ie_q), .if_flags(if_q), .nirq);

`default_nettype wire

// File: tb_gba_io.sv
// Testbench for the GBA I/O block with bus master, pad model and stimulus table
`timescale 1ns/1ps
`default_nettype none

module tb_gba_io;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_IRQ, OP_PAD, OP_SW, OP_NIRQ} op_t;
    typedef struct {
        op_t            op;
        gba_pkg::addr_t ofs;
        gba_pkg::word_t data;
        gba_pkg::sel_t  sel;
        gba_pkg::word_t exp;
    } row_t;

    // Latch, sixteen clocked bits, then the idle and done cycles
    localparam int FRAME_CYCLES = 34 * gba_pkg::PAD_HALF_PERIOD + 2;
    localparam int ACK_LIMIT = 16;
    localparam gba_pkg::half_t PAD_PATTERN = 16'hA5C3;
    localparam gba_pkg::half_t IRQ_BIT = 16'h1 << gba_pkg::IRQ_TIMER1;

    logic           clock;
    logic           arst_n;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    gba_pkg::addr_t wb_adr;
    gba_pkg::word_t wb_dat_w;
    gba_pkg::sel_t  wb_sel;
    gba_pkg::word_t wb_dat_r;
    logic           wb_ack;
    gba_pkg::irq_t  irq_sources;
    logic           nirq;
    logic           pad_latch;
    logic           pad_clock;
    logic           pad_data;
    gba_pkg::led_t  sw;
    gba_pkg::led_t  led;

    row_t           rows [64];
    int             n_rows = 0;
    logic           table_ready = 1'b0;
    gba_pkg::word_t led_model [4] = '{default: '0};
    gba_pkg::half_t pad_pattern;
    gba_pkg::half_t pad_sr = '0;
    logic           pad_clock_q = 1'b0;
    integer         seed = 32'hfa0c_39af;
    int             word_errors = 0;
    int             led_errors = 0;
    int             nirq_errors = 0;
    int             timeout_errors = 0;

    gba_io_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Pad model where pressed buttons pull the wire low
    always @(negedge clock) begin
        if (pad_latch) begin
            pad_sr <= pad_pattern;
        end else if (pad_clock && !pad_clock_q) begin
            pad_sr <= pad_sr >> 1;
        end
        pad_clock_q <= pad_clock;
    end
    assign pad_data = ~pad_sr[0];

    function automatic gba_pkg::addr_t led_ofs(input int r);
        return gba_pkg::addr_t'(gba_pkg::LED_REG0_OFS + 4 * r);
    endfunction

    task automatic add_row(input op_t op, input gba_pkg::addr_t ofs, input gba_pkg::word_t data,
                           input gba_pkg::sel_t sel, input gba_pkg::word_t exp);
        rows[n_rows] = '{op, ofs, data, sel, exp};
        n_rows++;
    endtask

    // Random write whose model keeps only the selected lanes
    task automatic add_led_write(input int r, input gba_pkg::sel_t sel);
        gba_pkg::word_t data;
        gba_pkg::word_t mask;
        data = $random(seed);
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{sel[b]}};
        end
        led_model[r] = (led_model[r] & ~mask) | (data & mask);
        add_row(OP_WR, led_ofs(r), data, sel, '0);
    endtask

    task automatic build_table();
        gba_pkg::led_t view;
        for (int r = 0; r < 4; r++) begin
            add_led_write(r, 4'hF);
        end
        add_led_write(1, 4'b0101);
        add_led_write(3, 4'b1000);
        add_led_write(0, 4'b0010);
        for (int r = 0; r < 4; r++) begin
            add_row(OP_RD, led_ofs(r), '0, 4'hF, led_model[r]);
        end
        add_row(OP_RD, 12'h100, '0, 4'hF, '0);
        // Switch value s shows byte s mod 4 of register s div 4
        for (int s = 0; s < 16; s++) begin
            view = gba_pkg::led_t'(led_model[s / 4] >> (8 * (s % 4)));
            add_row(OP_SW, '0, gba_pkg::word_t'(s), '0, {24'h0, view});
        end
        add_row(OP_PAD, '0, {16'h0, PAD_PATTERN}, '0, '0);
        add_row(OP_RD, gba_pkg::KEYINPUT_OFS, '0, 4'hF, {16'h0, PAD_PATTERN});
        add_row(OP_SW, '0, 32'h10, '0, {24'h0, PAD_PATTERN[7:0]});
        add_row(OP_SW, '0, 32'h80, '0, {24'h0, PAD_PATTERN[15:8]});
        add_row(OP_IRQ, '0, {16'h0, IRQ_BIT}, '0, '0);
        add_row(OP_WR, gba_pkg::IE_IF_OFS, {16'h0, IRQ_BIT}, 4'b0011, '0);
        add_row(OP_WR, gba_pkg::IME_OFS, 32'h1, 4'b0001, '0);
        add_row(OP_RD, gba_pkg::IE_IF_OFS, '0, 4'hF, {IRQ_BIT, IRQ_BIT});
        add_row(OP_NIRQ, '0, '0, '0, 32'h0);
        // Acknowledge through the IF lanes
        add_row(OP_WR, gba_pkg::IE_IF_OFS, {IRQ_BIT, 16'h0}, 4'b1100, '0);
        add_row(OP_RD, gba_pkg::IE_IF_OFS, '0, 4'hF, {16'h0, IRQ_BIT});
        add_row(OP_NIRQ, '0, '0, '0, 32'h1);
        add_row(OP_WR, gba_pkg::IME_OFS, 32'h0, 4'b0001, '0);
        add_row(OP_IRQ, '0, {16'h0, IRQ_BIT}, '0, '0);
        add_row(OP_RD, gba_pkg::IE_IF_OFS, '0, 4'hF, {IRQ_BIT, IRQ_BIT});
        add_row(OP_NIRQ, '0, '0, '0, 32'h1);
        table_ready = 1'b1;
    endtask

    task automatic check_word(input gba_pkg::word_t got, input gba_pkg::word_t exp, input int row);
        if (got !== exp) begin
            $display("** Error: wb_dat_r = 0x%08h, expected 0x%08h at row %0d", got, exp, row);
            word_errors++;
        end
    endtask

    task automatic check_led(input gba_pkg::led_t got, input gba_pkg::led_t exp, input int row);
        if (got !== exp) begin
            $display("** Error: led = 0x%02h, expected 0x%02h at row %0d", got, exp, row);
            led_errors++;
        end
    endtask

    task automatic check_nirq(input logic got, input logic exp, input int row);
        if (got !== exp) begin
            $display("** Error: nirq = 0x%0h, expected 0x%0h at row %0d", got, exp, row);
            nirq_errors++;
        end
    endtask

    task automatic bus_access(input logic we, input gba_pkg::addr_t ofs, input gba_pkg::word_t data,
                              input gba_pkg::sel_t sel, output gba_pkg::word_t rdata);
        int waited;
        waited = 0;
        @(negedge clock);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = ofs;
        wb_dat_w = data;
        wb_sel = sel;
        @(negedge clock);
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (!wb_ack) begin
            $display("Bus access to offset 0x%03h was never acknowledged", ofs);
            timeout_errors++;
        end
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    // Each latch rise starts a frame, so two rises cover one complete frame
    task automatic wait_pad_frames(input int frames);
        int   rises;
        int   waited;
        logic prev;
        rises = 0;
        waited = 0;
        prev = pad_latch;
        while (rises < frames && waited < 2 * frames * FRAME_CYCLES) begin
            @(negedge clock);
            if (pad_latch && !prev) begin
                rises++;
            end
            prev = pad_latch;
            waited++;
        end
        if (rises < frames) begin
            $display("Pad latch did not start %0d frames in time", frames);
            timeout_errors++;
        end
    endtask

    task automatic apply_row(input int i);
        gba_pkg::word_t rdata;
        case (rows[i].op)
            OP_WR: bus_access(1'b1, rows[i].ofs, rows[i].data, rows[i].sel, rdata);
            OP_RD: begin
                bus_access(1'b0, rows[i].ofs, '0, rows[i].sel, rdata);
                check_word(rdata, rows[i].exp, i);
            end
            OP_IRQ: begin
                @(negedge clock);
                irq_sources = rows[i].data[gba_pkg::NUM_IRQ-1:0];
                repeat (2) @(negedge clock);
                irq_sources = '0;
                repeat (2) @(negedge clock);
            end
            OP_PAD: begin
                pad_pattern = rows[i].data[15:0];
                wait_pad_frames(2);
            end
            OP_SW: begin
                @(negedge clock);
                sw = rows[i].data[7:0];
                @(negedge clock);
                check_led(led, rows[i].exp[7:0], i);
            end
            OP_NIRQ: begin
                repeat (3) @(negedge clock);
                check_nirq(nirq, rows[i].exp[0], i);
            end
            default: ;
        endcase
    endtask

    initial begin
        wait (table_ready);
        repeat (n_rows * 4 * FRAME_CYCLES) @(posedge clock);
        $display("Watchdog expired, the run took longer than %0d pad frames", n_rows * 4);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        irq_sources = '0;
        sw = '0;
        pad_pattern = '0;
        arst_n = 1'b0;
        build_table();
        repeat (8) @(negedge clock);
        arst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        $display("Errors: word %0d, led %0d, nirq %0d, timeout %0d",
                 word_errors, led_errors, nirq_errors, timeout_errors);
        if (word_errors + led_errors + nirq_errors + timeout_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
gba_pkg.sv
gba_bus_if.sv
io_reg_file.sv
interrupt_controller.sv
snes_pad_reader.sv
led_debug_mux.sv
gba_io_top.sv
gba_io_sva.sv
tb_gba_io.sv

// File: Makefile
TOP := tb_gba_io

.PHONY: all run clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard *.sv)
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^TEST OK$$' sim.log

clean:
	rm -rf obj_dir sim.log
